// File: compile.f
rtl/pinmux_pkg.sv
rtl/reg_access_if.sv
rtl/reg_bus_slave.sv
rtl/glbl_cfg_regs.sv
rtl/gpio_regs.sv
rtl/pinmux_reg_top.sv
dv/pinmux_reg_tb.sv

// File: dv/pinmux_reg_tb.sv
`timescale 1ns/1ns
`default_nettype none

module pinmux_reg_tb;

  localparam int GPIO_W      = 32;
  localparam int CLK_HALF    = 20;
  localparam int RST_CYCLES  = 5;
  localparam int BUS_TIMEOUT = 16;
  localparam int N_RAND      = 40;
  localparam int N_IRQ       = 8;
  localparam int N_IN        = 4;
  localparam logic [31:0] SEED = 32'he482e0ea;
  // Worst case about four cycles per access, doubled for margin
  localparam int N_ACCESS = 16 + 2 * N_RAND + 8 * N_IRQ + 10 * N_IRQ + 4 * N_IN;
  localparam int WATCHDOG_CYCLES = 2 * (RST_CYCLES + 4 * N_ACCESS);

  logic              mclk;
  logic              h_reset_n;
  logic              reg_cs;
  logic              reg_wr;
  logic [5:0]        reg_addr;
  logic [31:0]       reg_wdata;
  logic [3:0]        reg_be;
  logic [31:0]       reg_rdata;
  logic              reg_ack;
  logic [1:0]        ext_intr_in;
  logic              usb_intr;
  logic              i2cm_intr;
  logic [2:0]        timer_intr;
  logic [GPIO_W-1:0] gpio_in_data;
  logic [GPIO_W-1:0] gpio_int_event;
  logic [1:0]        cpu_core_rst_n;
  logic              cpu_intf_rst_n;
  logic              qspim_rst_n;
  logic              sspim_rst_n;
  logic [1:0]        uart_rst_n;
  logic              i2cm_rst_n;
  logic              usb_rst_n;
  logic [7:0]        irq_lines;
  logic              soft_irq;
  logic [GPIO_W-1:0] cfg_gpio_out_data;
  logic [GPIO_W-1:0] cfg_gpio_dir_sel;
  logic [GPIO_W-1:0] cfg_gpio_data_in;
  logic [GPIO_W-1:0] gpio_prev_indata;

  // Register model, indexed by word offset
  logic [31:0] model [0:15];
  // One entry per bus access, in request order
  logic        pend_rd  [$];
  logic [31:0] pend_exp [$];
  logic [3:0]  pend_off [$];

  int          errors;
  int          checks;
  int unsigned seed_init;
  logic        ack_prev;
  logic        cmp_is_rd;
  logic [31:0] cmp_exp;
  logic [3:0]  cmp_off;
  logic [31:0] rnd_a;
  logic [31:0] rnd_b;
  logic [3:0]  rnd_off;
  logic [3:0]  rand_offs [0:3];

  pinmux_reg_top #(
    .GPIO_W (GPIO_W)
  ) uut (
    .mclk              (mclk),
    .h_reset_n         (h_reset_n),
    .reg_cs            (reg_cs),
    .reg_wr            (reg_wr),
    .reg_addr          (reg_addr),
    .reg_wdata         (reg_wdata),
    .reg_be            (reg_be),
    .reg_rdata         (reg_rdata),
    .reg_ack           (reg_ack),
    .ext_intr_in       (ext_intr_in),
    .usb_intr          (usb_intr),
    .i2cm_intr         (i2cm_intr),
    .timer_intr        (timer_intr),
    .gpio_in_data      (gpio_in_data),
    .gpio_int_event    (gpio_int_event),
    .cpu_core_rst_n    (cpu_core_rst_n),
    .cpu_intf_rst_n    (cpu_intf_rst_n),
    .qspim_rst_n       (qspim_rst_n),
    .sspim_rst_n       (sspim_rst_n),
    .uart_rst_n        (uart_rst_n),
    .i2cm_rst_n        (i2cm_rst_n),
    .usb_rst_n         (usb_rst_n),
    .irq_lines         (irq_lines),
    .soft_irq          (soft_irq),
    .cfg_gpio_out_data (cfg_gpio_out_data),
    .cfg_gpio_dir_sel  (cfg_gpio_dir_sel),
    .cfg_gpio_data_in  (cfg_gpio_data_in),
    .gpio_prev_indata  (gpio_prev_indata)
  );

  always #CLK_HALF mclk = ~mclk;

  // ----------------------------------------
  // Reference model
  // ----------------------------------------
  function automatic logic [31:0] lane_mask(input logic [3:0] be);
    logic [31:0] m;
    m = '0;
    for (int i = 0; i < 4; i++) begin
      m[8*i +: 8] = {8{be[i]}};
    end
    return m;
  endfunction

  // Expected read data per word offset
  function automatic logic [31:0] ref_read(input logic [3:0] off);
    case (off)
      4'd0:                      return 32'h8268_2301;
      4'd1, 4'd2:                return model[off];
      // Sticky bits 7..0 plus soft bit 8
      4'd3:                      return model[3] & 32'h0000_01ff;
      4'd8, 4'd9, 4'd10, 4'd13:  return model[off];
      // Set offset mirrors the GPIO status
      4'd11, 4'd12:              return model[11];
      default:                   return 32'h0;
    endcase
  endfunction

  task automatic log_error(input string msg);
    errors++;
    $display("Error at %0t ns: %s", $time, msg);
  endtask

  // GPIO summary feeds global status bit 7
  task automatic refresh_gpio_summary();
    if (|(model[11] & model[13])) begin
      model[3][7] = 1'b1;
    end
  endtask

  task automatic apply_write(input logic [3:0] off, input logic [31:0] data,
                             input logic [3:0] be);
    logic [31:0] m;
    m = lane_mask(be);
    case (off)
      4'd1, 4'd2, 4'd9, 4'd10, 4'd13: model[off] = (model[off] & ~m) | (data & m);
      4'd3: begin
        model[3][7:0] = model[3][7:0] & ~(data[7:0] & m[7:0]);
        if (be[1]) begin
          model[3][8] = data[8];
        end
      end
      4'd11: model[11] = model[11] & ~(data & m);
      4'd12: model[11] = model[11] | (data & m);
      default: ;
    endcase
    refresh_gpio_summary();
  endtask

  // ----------------------------------------
  // Bus and pin stimulus
  // ----------------------------------------
  // Starts 2 ns after an edge, ends 2 ns after the idle cycle
  task automatic run_access(input logic wr, input logic [3:0] off,
                            input logic [31:0] data, input logic [3:0] be);
    int waits;
    pend_rd.push_back(!wr);
    pend_exp.push_back(wr ? 32'h0 : ref_read(off));
    pend_off.push_back(off);
    reg_cs    = 1'b1;
    reg_wr    = wr;
    reg_addr  = {off, 2'b00};
    reg_wdata = data;
    reg_be    = be;
    @(posedge mclk);
    #2;
    waits = 1;
    while (!reg_ack && waits < BUS_TIMEOUT) begin
      @(posedge mclk);
      #2;
      waits++;
    end
    if (!reg_ack) begin
      errors++;
      $display("Bus access to offset %0d was never acknowledged", off);
    end else begin
      checks++;
      assert (waits == 1)
        else log_error($sformatf("offset %0d acknowledged after %0d cycles, expected 1",
                                 off, waits));
    end
    // Drop the request inside the ack cycle
    reg_cs = 1'b0;
    reg_wr = 1'b0;
    if (wr) begin
      apply_write(off, data, be);
    end
    @(posedge mclk);
    #2;
  endtask

  task automatic write_reg(input logic [3:0] off, input logic [31:0] data,
                           input logic [3:0] be);
    run_access(1'b1, off, data, be);
  endtask

  task automatic read_reg(input logic [3:0] off);
    run_access(1'b0, off, 32'h0, 4'hf);
  endtask

  // Bits 6..0 are ext, usb, i2cm, timer
  task automatic pulse_hw_intr(input logic [6:0] v);
    {ext_intr_in, usb_intr, i2cm_intr, timer_intr} = v;
    @(posedge mclk);
    #2;
    {ext_intr_in, usb_intr, i2cm_intr, timer_intr} = '0;
    model[3][6:0] = model[3][6:0] | v;
    @(posedge mclk);
    #2;
  endtask

  // Extra cycle lets the summary reach bit 7
  task automatic pulse_gpio_event(input logic [31:0] v);
    gpio_int_event = v;
    @(posedge mclk);
    #2;
    gpio_int_event = '0;
    model[11] = model[11] | v;
    refresh_gpio_summary();
    @(posedge mclk);
    #2;
  endtask

  task automatic check_outputs();
    logic [8:0] exp_rst;
    logic [8:0] act_rst;
    exp_rst = {model[1][9:8], model[1][0], model[1][1], model[1][2],
               model[1][6], model[1][3], model[1][4], model[1][5]};
    act_rst = {cpu_core_rst_n, cpu_intf_rst_n, qspim_rst_n, sspim_rst_n,
               uart_rst_n, i2cm_rst_n, usb_rst_n};
    checks += 5;
    assert (act_rst === exp_rst)
      else log_error($sformatf("reset outputs %b, expected %b", act_rst, exp_rst));
    assert (irq_lines === (model[3][7:0] & model[2][7:0]))
      else log_error($sformatf("irq_lines %h, expected %h", irq_lines,
                               model[3][7:0] & model[2][7:0]));
    assert (soft_irq === (model[3][8] & model[2][8]))
      else log_error($sformatf("soft_irq %b, expected %b", soft_irq,
                               model[3][8] & model[2][8]));
    assert (cfg_gpio_out_data === model[9])
      else log_error($sformatf("cfg_gpio_out_data %h, expected %h",
                               cfg_gpio_out_data, model[9]));
    assert (cfg_gpio_dir_sel === model[10])
      else log_error($sformatf("cfg_gpio_dir_sel %h, expected %h",
                               cfg_gpio_dir_sel, model[10]));
  endtask

  // ----------------------------------------
  // Read checker and ack width
  // ----------------------------------------
  // Sampled mid-cycle, away from the capture edge
  always @(negedge mclk) begin
    if (h_reset_n) begin
      assert (!(reg_ack && ack_prev))
        else log_error("reg_ack held high for two cycles");
      if (reg_ack) begin
        if (pend_rd.size() == 0) begin
          errors++;
          $display("Acknowledge seen with no access outstanding");
        end else begin
          cmp_is_rd = pend_rd.pop_front();
          cmp_exp   = pend_exp.pop_front();
          cmp_off   = pend_off.pop_front();
          if (cmp_is_rd) begin
            checks++;
            assert (reg_rdata === cmp_exp)
              else log_error($sformatf("offset %0d read %h, expected %h",
                                       cmp_off, reg_rdata, cmp_exp));
          end
        end
      end
      ack_prev = reg_ack;
    end
  end

  // Watchdog
  initial begin
    #(WATCHDOG_CYCLES * 2 * CLK_HALF);
    $display("Watchdog expired after %0d cycles, run did not finish", WATCHDOG_CYCLES);
    $display("Verification failed");
    $finish;
  end

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------
  initial begin
    mclk           = 1'b0;
    h_reset_n      = 1'b0;
    reg_cs         = 1'b0;
    reg_wr         = 1'b0;
    reg_addr       = '0;
    reg_wdata      = '0;
    reg_be         = '0;
    ext_intr_in    = '0;
    usb_intr       = 1'b0;
    i2cm_intr      = 1'b0;
    timer_intr     = '0;
    gpio_in_data   = '0;
    gpio_int_event = '0;
    errors         = 0;
    checks         = 0;
    ack_prev       = 1'b0;
    seed_init      = $urandom(SEED);
    for (int i = 0; i < 16; i++) begin
      model[i] = '0;
    end
    // Control, mask, GPIO out, GPIO dir
    rand_offs[0] = 4'd1;
    rand_offs[1] = 4'd2;
    rand_offs[2] = 4'd9;
    rand_offs[3] = 4'd10;

    repeat (RST_CYCLES) @(posedge mclk);
    #2;
    h_reset_n = 1'b1;
    @(posedge mclk);
    #2;

    // Reset values, unmapped offsets included
    check_outputs();
    for (int i = 0; i < 16; i++) begin
      read_reg(i[3:0]);
    end

    // Byte-enabled config writes
    repeat (N_RAND) begin
      rnd_off = rand_offs[$urandom % 4];
      rnd_a   = $urandom;
      write_reg(rnd_off, rnd_a, $urandom);
      check_outputs();
      read_reg(rnd_off);
    end

    // Hardware interrupts and write-1-to-clear
    write_reg(4'd2, $urandom | 32'h0000_0100, 4'hf);
    repeat (N_IRQ) begin
      rnd_a = $urandom;
      pulse_hw_intr(rnd_a[6:0]);
      check_outputs();
      read_reg(4'd3);
      write_reg(4'd3, $urandom, $urandom);
      check_outputs();
      read_reg(4'd3);
    end

    // GPIO interrupt status, set and mask
    write_reg(4'd13, 32'h0000_ff0f, 4'hf);
    repeat (N_IRQ) begin
      pulse_gpio_event($urandom & $urandom);
      read_reg(4'd11);
      read_reg(4'd3);
      check_outputs();
      rnd_a = $urandom & $urandom;
      write_reg(4'd12, rnd_a, $urandom);
      read_reg(4'd12);
      write_reg(4'd11, $urandom, $urandom);
      read_reg(4'd11);
      // Bit 7 stays while the summary is high
      write_reg(4'd3, 32'h0000_0080, 4'h1);
      read_reg(4'd3);
    end
    write_reg(4'd11, 32'hffff_ffff, 4'hf);
    write_reg(4'd3, 32'h0000_0080, 4'h1);
    read_reg(4'd3);
    check_outputs();

    // Events outside the mask leave bit 7 low
    pulse_gpio_event(32'hffff_00f0);
    read_reg(4'd3);
    // One masked-in bit raises it
    pulse_gpio_event(32'h0000_0100);
    read_reg(4'd3);
    check_outputs();

    // GPIO input path, 2 then 3 cycles
    repeat (N_IN) begin
      rnd_b        = $urandom;
      gpio_in_data = rnd_b;
      @(posedge mclk);
      @(posedge mclk);
      #2;
      checks++;
      assert (gpio_prev_indata === rnd_b)
        else log_error($sformatf("gpio_prev_indata %h, expected %h",
                                 gpio_prev_indata, rnd_b));
      @(posedge mclk);
      #2;
      checks++;
      assert (cfg_gpio_data_in === rnd_b)
        else log_error($sformatf("cfg_gpio_data_in %h, expected %h",
                                 cfg_gpio_data_in, rnd_b));
      model[8] = rnd_b;
      read_reg(4'd8);
    end

    if (pend_rd.size() != 0) begin
      errors++;
      $display("%0d bus accesses were never acknowledged", pend_rd.size());
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: rtl/glbl_cfg_regs.sv
`timescale 1ns/1ns
`default_nettype none

module glbl_cfg_regs (
  input  wire logic                           mclk,
  input  wire logic                           h_reset_n,
  // Decoded access
  reg_access_if.regs                          acc,
  // Hardware interrupt sources
  input  wire logic [1:0]                     ext_intr_in,
  input  wire logic                           usb_intr,
  input  wire logic                           i2cm_intr,
  input  wire logic [2:0]                     timer_intr,
  input  wire logic                           gpio_intr,
  // Block resets, active low
  output logic [1:0]                          cpu_core_rst_n,
  output logic                                cpu_intf_rst_n,
  output logic                                qspim_rst_n,
  output logic                                sspim_rst_n,
  output logic [1:0]                          uart_rst_n,
  output logic                                i2cm_rst_n,
  output logic                                usb_rst_n,
  // Masked interrupts to the core
  output logic [pinmux_pkg::HW_INTR_W-1:0]    irq_lines,
  output logic                                soft_irq
);

  localparam int HW = pinmux_pkg::HW_INTR_W;
  localparam int SB = pinmux_pkg::SOFT_IRQ_BIT;

  pinmux_pkg::reg_word_t glbl_ctrl;
  pinmux_pkg::reg_word_t intr_mask;
  logic [SB:0]           intr_stat;
  logic [HW-1:0]         hw_req;
  logic [HW-1:0]         hw_clr;
  pinmux_pkg::reg_word_t wr_mask;
  logic                  ctrl_we;
  logic                  mask_we;
  logic                  stat_we;

  // ----------------------------------------
  // Write decode
  // ----------------------------------------
  assign wr_mask = pinmux_pkg::be_mask(acc.be);
  assign ctrl_we = acc.wr_stb & (acc.off == pinmux_pkg::OFF_GLBL_CTRL);
  assign mask_we = acc.wr_stb & (acc.off == pinmux_pkg::OFF_INTR_MASK);
  assign stat_we = acc.wr_stb & (acc.off == pinmux_pkg::OFF_INTR_STAT);

  // Pack the hardware sources
  always_comb begin
    hw_req = '0;
    hw_req[pinmux_pkg::INTR_TIMER_LSB +: 3] = timer_intr;
    hw_req[pinmux_pkg::INTR_I2CM_BIT]       = i2cm_intr;
    hw_req[pinmux_pkg::INTR_USB_BIT]        = usb_intr;
    hw_req[pinmux_pkg::INTR_EXT_LSB +: 2]   = ext_intr_in;
    hw_req[pinmux_pkg::INTR_GPIO_BIT]       = gpio_intr;
  end

  // Write-one-to-clear, byte 0 only
  assign hw_clr = {HW{stat_we}} & acc.wdata[HW-1:0] & wr_mask[HW-1:0];

  always_ff @(posedge mclk or negedge h_reset_n) begin
    if (!h_reset_n) begin
      glbl_ctrl <= '0;
      intr_mask <= '0;
      intr_stat <= '0;
    end else begin
      if (ctrl_we) begin
        glbl_ctrl <= (glbl_ctrl & ~wr_mask) | (acc.wdata & wr_mask);
      end
      if (mask_we) begin
        intr_mask <= (intr_mask & ~wr_mask) | (acc.wdata & wr_mask);
      end
      // Hardware set wins over a software clear
      intr_stat[HW-1:0] <= (intr_stat[HW-1:0] & ~hw_clr) | hw_req;
      // Soft interrupt is a plain bit
      if (stat_we && wr_mask[SB]) begin
        intr_stat[SB] <= acc.wdata[SB];
      end
    end
  end

  // ----------------------------------------
  // Outputs and read mux
  // ----------------------------------------
  assign cpu_intf_rst_n = glbl_ctrl[pinmux_pkg::RST_CPU_INTF_BIT];
  assign qspim_rst_n    = glbl_ctrl[pinmux_pkg::RST_QSPIM_BIT];
  assign sspim_rst_n    = glbl_ctrl[pinmux_pkg::RST_SSPIM_BIT];
  assign uart_rst_n[0]  = glbl_ctrl[pinmux_pkg::RST_UART0_BIT];
  assign i2cm_rst_n     = glbl_ctrl[pinmux_pkg::RST_I2CM_BIT];
  assign usb_rst_n      = glbl_ctrl[pinmux_pkg::RST_USB_BIT];
  assign uart_rst_n[1]  = glbl_ctrl[pinmux_pkg::RST_UART1_BIT];
  assign cpu_core_rst_n = glbl_ctrl[pinmux_pkg::RST_CPU_CORE_LSB +: 2];

  assign irq_lines = intr_stat[HW-1:0] & intr_mask[HW-1:0];
  assign soft_irq  = intr_stat[SB] & intr_mask[SB];

  always_comb begin
    case (acc.off)
      pinmux_pkg::OFF_CHIP_ID:   acc.rdata = pinmux_pkg::CHIP_ID;
      pinmux_pkg::OFF_GLBL_CTRL: acc.rdata = glbl_ctrl;
      pinmux_pkg::OFF_INTR_MASK: acc.rdata = intr_mask;
      // Upper status bits read zero
      pinmux_pkg::OFF_INTR_STAT: acc.rdata = pinmux_pkg::reg_word_t'(intr_stat);
      default:                   acc.rdata = '0;
    endcase
  end

  // Any source request shows in status one cycle later
  hw_req_sets_stat: assert property (
    @(posedge mclk) disable iff (!h_reset_n)
    (hw_req != '0) |=> ((intr_stat[HW-1:0] & $past(hw_req)) == $past(hw_req))
  );

endmodule

`default_nettype wire

// File: rtl/gpio_regs.sv
`timescale 1ns/1ns
`default_nettype none

module gpio_regs #(
  parameter int GPIO_W = 32
) (
  input  wire logic              mclk,
  input  wire logic              h_reset_n,
  // Decoded access
  reg_access_if.regs             acc,
  // Pad side
  input  wire logic [GPIO_W-1:0] gpio_in_data,
  input  wire logic [GPIO_W-1:0] gpio_int_event,
  output logic [GPIO_W-1:0]      cfg_gpio_out_data,
  output logic [GPIO_W-1:0]      cfg_gpio_dir_sel,
  output logic [GPIO_W-1:0]      cfg_gpio_data_in,
  output logic [GPIO_W-1:0]      gpio_prev_indata,
  // To the global status
  output logic                   gpio_intr
);

  logic [GPIO_W-1:0] gpio_in_s;
  logic [GPIO_W-1:0] gpio_in_ss;
  logic [GPIO_W-1:0] gpio_in_cap;
  logic [GPIO_W-1:0] gpio_out;
  logic [GPIO_W-1:0] gpio_dir;
  logic [GPIO_W-1:0] gpio_istat;
  logic [GPIO_W-1:0] gpio_imask;
  logic [GPIO_W-1:0] wr_mask;
  logic [GPIO_W-1:0] wr_data;
  logic [GPIO_W-1:0] sw_set;
  logic [GPIO_W-1:0] sw_clr;
  logic              out_we;
  logic              dir_we;
  logic              istat_we;
  logic              iset_we;
  logic              imask_we;

  // ----------------------------------------
  // Input synchronizer and capture
  // ----------------------------------------
  always_ff @(posedge mclk or negedge h_reset_n) begin
    if (!h_reset_n) begin
      gpio_in_s   <= '0;
      gpio_in_ss  <= '0;
      gpio_in_cap <= '0;
    end else begin
      gpio_in_s   <= gpio_in_data;
      gpio_in_ss  <= gpio_in_s;
      // Third stage is the readable word
      gpio_in_cap <= gpio_in_ss;
    end
  end

  // Byte lanes cut to the pin count
  assign wr_mask = GPIO_W'(pinmux_pkg::be_mask(acc.be));
  assign wr_data = GPIO_W'(acc.wdata);

  assign out_we   = acc.wr_stb & (acc.off == pinmux_pkg::OFF_GPIO_OUT);
  assign dir_we   = acc.wr_stb & (acc.off == pinmux_pkg::OFF_GPIO_DIR);
  assign istat_we = acc.wr_stb & (acc.off == pinmux_pkg::OFF_GPIO_ISTAT);
  assign iset_we  = acc.wr_stb & (acc.off == pinmux_pkg::OFF_GPIO_ISET);
  assign imask_we = acc.wr_stb & (acc.off == pinmux_pkg::OFF_GPIO_IMASK);

  // Ones in enabled bytes set or clear status
  assign sw_clr = {GPIO_W{istat_we}} & wr_data & wr_mask;
  assign sw_set = {GPIO_W{iset_we}} & wr_data & wr_mask;

  // ----------------------------------------
  // Config and interrupt registers
  // ----------------------------------------
  always_ff @(posedge mclk or negedge h_reset_n) begin
    if (!h_reset_n) begin
      gpio_out   <= '0;
      gpio_dir   <= '0;
      gpio_istat <= '0;
      gpio_imask <= '0;
    end else begin
      if (out_we) begin
        gpio_out <= (gpio_out & ~wr_mask) | (wr_data & wr_mask);
      end
      if (dir_we) begin
        gpio_dir <= (gpio_dir & ~wr_mask) | (wr_data & wr_mask);
      end
      if (imask_we) begin
        gpio_imask <= (gpio_imask & ~wr_mask) | (wr_data & wr_mask);
      end
      // Event posting beats the host clear
      gpio_istat <= (gpio_istat & ~sw_clr) | sw_set | gpio_int_event;
    end
  end

  assign cfg_gpio_out_data = gpio_out;
  assign cfg_gpio_dir_sel  = gpio_dir;
  assign cfg_gpio_data_in  = gpio_in_cap;
  assign gpio_prev_indata  = gpio_in_ss;

  // Single interrupt toward the core
  assign gpio_intr = |(gpio_istat & gpio_imask);

  always_comb begin
    case (acc.off)
      pinmux_pkg::OFF_GPIO_IN:    acc.rdata = pinmux_pkg::reg_word_t'(gpio_in_cap);
      pinmux_pkg::OFF_GPIO_OUT:   acc.rdata = pinmux_pkg::reg_word_t'(gpio_out);
      pinmux_pkg::OFF_GPIO_DIR:   acc.rdata = pinmux_pkg::reg_word_t'(gpio_dir);
      pinmux_pkg::OFF_GPIO_ISTAT: acc.rdata = pinmux_pkg::reg_word_t'(gpio_istat);
      // Set register mirrors status
      pinmux_pkg::OFF_GPIO_ISET:  acc.rdata = pinmux_pkg::reg_word_t'(gpio_istat);
      pinmux_pkg::OFF_GPIO_IMASK: acc.rdata = pinmux_pkg::reg_word_t'(gpio_imask);
      default:                    acc.rdata = '0;
    endcase
  end

  // Fully masked status never raises the interrupt
  intr_low_when_masked: assert property (
    @(posedge mclk) disable iff (!h_reset_n)
    (gpio_imask == '0) |-> !gpio_intr
  );

endmodule

`default_nettype wire

// File: rtl/pinmux_pkg.sv
`default_nettype none

package pinmux_pkg;

  // ----------------------------------------
  // Register bus widths and types
  // ----------------------------------------
  localparam int DATA_W = 32;
  // Word offset bits, taken from byte address [5:2]
  localparam int ADDR_W = 4;

  typedef logic [DATA_W-1:0]   reg_word_t;
  typedef logic [DATA_W/8-1:0] be_t;
  // Offset inside one block, top offset bit picks the block
  typedef logic [ADDR_W-2:0]   reg_off_t;

  // ----------------------------------------
  // Register offsets
  // ----------------------------------------
  // Global block
  localparam reg_off_t OFF_CHIP_ID    = 3'd0;
  localparam reg_off_t OFF_GLBL_CTRL  = 3'd1;
  localparam reg_off_t OFF_INTR_MASK  = 3'd2;
  localparam reg_off_t OFF_INTR_STAT  = 3'd3;
  // GPIO block
  localparam reg_off_t OFF_GPIO_IN    = 3'd0;
  localparam reg_off_t OFF_GPIO_OUT   = 3'd1;
  localparam reg_off_t OFF_GPIO_DIR   = 3'd2;
  localparam reg_off_t OFF_GPIO_ISTAT = 3'd3;
  localparam reg_off_t OFF_GPIO_ISET  = 3'd4;
  localparam reg_off_t OFF_GPIO_IMASK = 3'd5;

  // Chip identification fields
  localparam logic [15:0] MANU_ID  = 16'h8268;
  localparam logic [3:0]  CORE_CNT = 4'h2;
  localparam logic [3:0]  CHIP_NUM = 4'h3;
  localparam logic [7:0]  CHIP_REV = 8'h01;
  localparam reg_word_t   CHIP_ID  = {MANU_ID, CORE_CNT, CHIP_NUM, CHIP_REV};

  // ----------------------------------------
  // Interrupt bit positions
  // ----------------------------------------
  localparam int HW_INTR_W      = 8;
  localparam int INTR_TIMER_LSB = 0;
  localparam int INTR_I2CM_BIT  = 3;
  localparam int INTR_USB_BIT   = 4;
  localparam int INTR_EXT_LSB   = 5;
  localparam int INTR_GPIO_BIT  = 7;
  localparam int SOFT_IRQ_BIT   = 8;

  // Block reset bits in the control word
  localparam int RST_CPU_INTF_BIT = 0;
  localparam int RST_QSPIM_BIT    = 1;
  localparam int RST_SSPIM_BIT    = 2;
  localparam int RST_UART0_BIT    = 3;
  localparam int RST_I2CM_BIT     = 4;
  localparam int RST_USB_BIT      = 5;
  localparam int RST_UART1_BIT    = 6;
  localparam int RST_CPU_CORE_LSB = 8;

  // Byte enables widened to a bit mask
  function automatic reg_word_t be_mask(input be_t be);
    return {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
  endfunction

endpackage

`default_nettype wire

// File: rtl/pinmux_reg_top.sv
`timescale 1ns/1ns
`default_nettype none

module pinmux_reg_top #(
  parameter int GPIO_W = 32
) (
  input  wire logic                           mclk,
  input  wire logic                           h_reset_n,
  // Register bus
  input  wire logic                           reg_cs,
  input  wire logic                           reg_wr,
  input  wire logic [5:0]                     reg_addr,
  input  wire pinmux_pkg::reg_word_t          reg_wdata,
  input  wire pinmux_pkg::be_t                reg_be,
  output pinmux_pkg::reg_word_t               reg_rdata,
  output logic                                reg_ack,
  // Interrupt sources
  input  wire logic [1:0]                     ext_intr_in,
  input  wire logic                           usb_intr,
  input  wire logic                           i2cm_intr,
  input  wire logic [2:0]                     timer_intr,
  // GPIO pads
  input  wire logic [GPIO_W-1:0]              gpio_in_data,
  input  wire logic [GPIO_W-1:0]              gpio_int_event,
  // Block resets
  output logic [1:0]                          cpu_core_rst_n,
  output logic                                cpu_intf_rst_n,
  output logic                                qspim_rst_n,
  output logic                                sspim_rst_n,
  output logic [1:0]                          uart_rst_n,
  output logic                                i2cm_rst_n,
  output logic                                usb_rst_n,
  // To the core
  output logic [pinmux_pkg::HW_INTR_W-1:0]    irq_lines,
  output logic                                soft_irq,
  // GPIO config
  output logic [GPIO_W-1:0]                   cfg_gpio_out_data,
  output logic [GPIO_W-1:0]                   cfg_gpio_dir_sel,
  output logic [GPIO_W-1:0]                   cfg_gpio_data_in,
  output logic [GPIO_W-1:0]                   gpio_prev_indata
);

  // One access channel per block
  reg_access_if glbl_acc ();
  reg_access_if gpio_acc ();

  // GPIO summary into global status bit 7
  logic gpio_intr;

  reg_bus_slave u_bus (
    .mclk      (mclk),
    .h_reset_n (h_reset_n),
    .reg_cs    (reg_cs),
    .reg_wr    (reg_wr),
    .reg_addr  (reg_addr),
    .reg_wdata (reg_wdata),
    .reg_be    (reg_be),
    .reg_rdata (reg_rdata),
    .reg_ack   (reg_ack),
    .glbl_acc  (glbl_acc),
    .gpio_acc  (gpio_acc)
  );

  glbl_cfg_regs u_glbl (
    .mclk           (mclk),
    .h_reset_n      (h_reset_n),
    .acc            (glbl_acc),
    .ext_intr_in    (ext_intr_in),
    .usb_intr       (usb_intr),
    .i2cm_intr      (i2cm_intr),
    .timer_intr     (timer_intr),
    .gpio_intr      (gpio_intr),
    .cpu_core_rst_n (cpu_core_rst_n),
    .cpu_intf_rst_n (cpu_intf_rst_n),
    .qspim_rst_n    (qspim_rst_n),
    .sspim_rst_n    (sspim_rst_n),
    .uart_rst_n     (uart_rst_n),
    .i2cm_rst_n     (i2cm_rst_n),
    .usb_rst_n      (usb_rst_n),
    .irq_lines      (irq_lines),
    .soft_irq       (soft_irq)
  );

  gpio_regs #(
    .GPIO_W (GPIO_W)
  ) u_gpio (
    .mclk              (mclk),
    .h_reset_n         (h_reset_n),
    .acc               (gpio_acc),
    .gpio_in_data      (gpio_in_data),
    .gpio_int_event    (gpio_int_event),
    .cfg_gpio_out_data (cfg_gpio_out_data),
    .cfg_gpio_dir_sel  (cfg_gpio_dir_sel),
    .cfg_gpio_data_in  (cfg_gpio_data_in),
    .gpio_prev_indata  (gpio_prev_indata),
    .gpio_intr         (gpio_intr)
  );

endmodule

`default_nettype wire

// File: rtl/reg_access_if.sv
`timescale 1ns/1ns
`default_nettype none

// Decoded register access into one block
interface reg_access_if;

  // Commit pulse, only for the selected block
  logic                  wr_stb;
  // Word offset inside the block
  pinmux_pkg::reg_off_t  off;
  pinmux_pkg::reg_word_t wdata;
  pinmux_pkg::be_t       be;
  // Combinational read of the word at off
  pinmux_pkg::reg_word_t rdata;

  // Bus slave side
  modport bus (
    output wr_stb,
    output off,
    output wdata,
    output be,
    input  rdata
  );

  // Register block side
  modport regs (
    input  wr_stb,
    input  off,
    input  wdata,
    input  be,
    output rdata
  );

endinterface

`default_nettype wire

// File: rtl/reg_bus_slave.sv
`timescale 1ns/1ns
`default_nettype none

module reg_bus_slave (
  input  wire logic                          mclk,
  input  wire logic                          h_reset_n,
  // Register bus
  input  wire logic                          reg_cs,
  input  wire logic                          reg_wr,
  input  wire logic [pinmux_pkg::ADDR_W+1:0] reg_addr,
  input  wire pinmux_pkg::reg_word_t         reg_wdata,
  input  wire pinmux_pkg::be_t               reg_be,
  output pinmux_pkg::reg_word_t              reg_rdata,
  output logic                               reg_ack,
  // Block access ports
  reg_access_if.bus                          glbl_acc,
  reg_access_if.bus                          gpio_acc
);

  logic [pinmux_pkg::ADDR_W-1:0] word_off;
  logic                          gpio_sel;
  logic                          acc_en;
  pinmux_pkg::reg_word_t         rd_mux;

  // ----------------------------------------
  // Address decode
  // ----------------------------------------
  // Drop the byte address bits
  assign word_off = reg_addr[pinmux_pkg::ADDR_W+1:2];
  // Upper offset bit picks GPIO
  assign gpio_sel = word_off[pinmux_pkg::ADDR_W-1];

  // Request cycle not yet acknowledged
  assign acc_en = reg_cs & ~reg_ack;

  // Same offset and data to both blocks
  assign glbl_acc.off   = word_off[pinmux_pkg::ADDR_W-2:0];
  assign glbl_acc.wdata = reg_wdata;
  assign glbl_acc.be    = reg_be;
  assign gpio_acc.off   = word_off[pinmux_pkg::ADDR_W-2:0];
  assign gpio_acc.wdata = reg_wdata;
  assign gpio_acc.be    = reg_be;

  // Strobe only into the selected block
  assign glbl_acc.wr_stb = acc_en & reg_wr & ~gpio_sel;
  assign gpio_acc.wr_stb = acc_en & reg_wr &  gpio_sel;

  // Read data from the selected block
  assign rd_mux = gpio_sel ? gpio_acc.rdata : glbl_acc.rdata;

  // ----------------------------------------
  // Acknowledge and read capture
  // ----------------------------------------
  always_ff @(posedge mclk or negedge h_reset_n) begin
    if (!h_reset_n) begin
      reg_ack   <= 1'b0;
      reg_rdata <= '0;
    end else begin
      // Ack for one cycle, then a gap
      reg_ack <= acc_en;
      if (acc_en) begin
        reg_rdata <= rd_mux;
      end
    end
  end

  // A held request never gets back-to-back acks
  ack_single_cycle: assert property (
    @(posedge mclk) disable iff (!h_reset_n)
    reg_ack |=> !reg_ack
  );

endmodule

`default_nettype wire
